// ==== logic/cp0Pkg.sv ====
//**********************************************************
// architectural register definitions for the CP0 block
// register numbers, word types and field bit positions
// shared by the timer, the register file and the testbench
//**********************************************************

package cp0Pkg;

    typedef logic [31:0] word_t;     // one data word
    typedef logic [4:0]  regAddr_t;  // coprocessor register number

    //**********************************************************
    // register numbers
    //**********************************************************
    parameter regAddr_t RegBadVAddr = 5'd8;
    parameter regAddr_t RegCount    = 5'd9;
    parameter regAddr_t RegCompare  = 5'd11;
    parameter regAddr_t RegStatus   = 5'd12;
    parameter regAddr_t RegCause    = 5'd13;
    parameter regAddr_t RegEpc      = 5'd14;

    // only CU0 set, coprocessor 0 usable
    parameter word_t StatusReset = 32'h1000_0000;

    //**********************************************************
    // Status fields
    //**********************************************************
    parameter int StatusImHi = 15;  // interrupt mask
    parameter int StatusImLo = 8;
    parameter int StatusExl  = 1;   // exception level
    parameter int StatusIe   = 0;   // global interrupt enable

    //**********************************************************
    // Cause fields
    //**********************************************************
    parameter int CauseBd     = 31;  // branch delay slot
    parameter int CauseTi     = 30;  // timer interrupt pending
    parameter int CauseHwIpHi = 15;  // hardware IP7..IP2
    parameter int CauseHwIpLo = 10;
    parameter int CauseSwIpHi = 9;   // software IP1..IP0
    parameter int CauseSwIpLo = 8;
    parameter int CauseExcHi  = 6;   // exception code
    parameter int CauseExcLo  = 2;

endpackage

// ==== logic/excPkg.sv ====
//**********************************************************
// exception reporting definitions
// flag vector layout as driven by the pipeline, the
// exception codes written into Cause and the interrupt lines
//**********************************************************

package excPkg;

    // one flag per event, bit 8 has the highest priority
    typedef logic [8:0] excFlags_t;

    parameter int FlagInt     = 8;
    parameter int FlagAdIf    = 7;  // fetch address error
    parameter int FlagRi      = 6;  // reserved instruction
    parameter int FlagSys     = 5;
    parameter int FlagBp      = 4;
    parameter int FlagEret    = 3;  // not an exception, returns from one
    parameter int FlagOv      = 2;
    parameter int FlagAdStore = 1;
    parameter int FlagAdLoad  = 0;

    typedef logic [4:0] excCode_t;

    //**********************************************************
    // exception codes
    //**********************************************************
    parameter excCode_t ExcInt  = 5'd0;
    parameter excCode_t ExcAdEL = 5'd4;
    parameter excCode_t ExcAdES = 5'd5;
    parameter excCode_t ExcSys  = 5'd8;
    parameter excCode_t ExcBp   = 5'd9;
    parameter excCode_t ExcRi   = 5'd10;
    parameter excCode_t ExcOv   = 5'd12;

    // external hardware interrupt lines
    parameter int HwIntWidth = 6;
    typedef logic [HwIntWidth-1:0] hwInt_t;

endpackage

// ==== logic/excPrioritizer.sv ====
//**********************************************************
// fixed priority encoder for the pipeline exception flags
// picks the highest raised flag, gives its exception code
// and tells the register block where BadVAddr comes from
//**********************************************************

`timescale 1ns/1ps

module excPrioritizer (
    input  excPkg::excFlags_t flags_i,
    output logic              excTake_o,
    output excPkg::excCode_t  excCode_o,
    output logic              eretTake_o,
    output logic              badFromPc_o,
    output logic              badFromVaddr_o
);

    always_comb begin
        excTake_o      = 1'b0;
        excCode_o      = excPkg::ExcInt;
        eretTake_o     = 1'b0;
        badFromPc_o    = 1'b0;
        badFromVaddr_o = 1'b0;

        // first raised flag wins, everything below is dropped
        if (flags_i[excPkg::FlagInt]) begin
            excTake_o = 1'b1;
            excCode_o = excPkg::ExcInt;
        end else if (flags_i[excPkg::FlagAdIf]) begin
            excTake_o   = 1'b1;
            excCode_o   = excPkg::ExcAdEL;
            badFromPc_o = 1'b1;  // fetch address is the pc itself
        end else if (flags_i[excPkg::FlagRi]) begin
            excTake_o = 1'b1;
            excCode_o = excPkg::ExcRi;
        end else if (flags_i[excPkg::FlagSys]) begin
            excTake_o = 1'b1;
            excCode_o = excPkg::ExcSys;
        end else if (flags_i[excPkg::FlagBp]) begin
            excTake_o = 1'b1;
            excCode_o = excPkg::ExcBp;
        end else if (flags_i[excPkg::FlagEret]) begin
            // eret masks the lower data-side faults
            eretTake_o = 1'b1;
        end else if (flags_i[excPkg::FlagOv]) begin
            excTake_o = 1'b1;
            excCode_o = excPkg::ExcOv;
        end else if (flags_i[excPkg::FlagAdStore]) begin
            excTake_o      = 1'b1;
            excCode_o      = excPkg::ExcAdES;
            badFromVaddr_o = 1'b1;
        end else if (flags_i[excPkg::FlagAdLoad]) begin
            excTake_o      = 1'b1;
            excCode_o      = excPkg::ExcAdEL;
            badFromVaddr_o = 1'b1;
        end
    end

endmodule

// ==== logic/cp0Timer.sv ====
//**********************************************************
// Count and Compare registers with the divided count tick
// Count steps once every CountDiv cycles, a match against a
// nonzero Compare raises a sticky interrupt until the next
// Compare write
//**********************************************************

`timescale 1ns/1ps

module cp0Timer #(
    parameter int CountDiv = 2
) (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              wrEn_i,
    input  cp0Pkg::regAddr_t  wrAddr_i,
    input  cp0Pkg::word_t     wrData_i,
    output cp0Pkg::word_t     count_o,
    output cp0Pkg::word_t     compare_o,
    output logic              timerInt_o,
    output logic              timerMatch_o
);

    localparam int PhaseW = (CountDiv > 1) ? $clog2(CountDiv) : 1;

    logic [PhaseW-1:0] phase;  // divider phase
    logic              countWr;
    logic              compareWr;
    logic              tick;

    assign countWr   = wrEn_i && (wrAddr_i == cp0Pkg::RegCount);
    assign compareWr = wrEn_i && (wrAddr_i == cp0Pkg::RegCompare);
    assign tick      = (phase == PhaseW'(CountDiv - 1));

    // a Compare write in the same cycle masks the match
    assign timerMatch_o = (compare_o != '0) && (count_o == compare_o) && !compareWr;

    //**********************************************************
    // count and divider
    //**********************************************************
    always_ff @(posedge clk) begin
        if (reset_i) begin
            count_o <= '0;
            phase   <= '0;
        end else if (countWr) begin
            count_o <= wrData_i;
            phase   <= '0;  // restart so the next step is CountDiv away
        end else if (tick) begin
            count_o <= count_o + 32'd1;
            phase   <= '0;
        end else begin
            phase <= phase + 1'b1;
        end
    end

    //**********************************************************
    // compare and interrupt
    //**********************************************************
    always_ff @(posedge clk) begin
        if (reset_i) begin
            compare_o  <= '0;
            timerInt_o <= 1'b0;
        end else if (compareWr) begin
            compare_o  <= wrData_i;
            timerInt_o <= 1'b0;  // acknowledge
        end else if (timerMatch_o) begin
            timerInt_o <= 1'b1;
        end
    end

endmodule

// ==== logic/cp0Regs.sv ====
//**********************************************************
// Status, Cause, EPC and BadVAddr with exception capture
// software writes go through the field masks, exceptions
// override them in the same cycle, reads are combinational
//**********************************************************

`timescale 1ns/1ps

module cp0Regs (
    input  logic              clk,
    input  logic              reset_i,

    // software write port
    input  logic              wrEn_i,
    input  cp0Pkg::regAddr_t  wrAddr_i,
    input  cp0Pkg::word_t     wrData_i,

    input  cp0Pkg::regAddr_t  rdAddr_i,

    // from the prioritizer
    input  logic              excTake_i,
    input  excPkg::excCode_t  excCode_i,
    input  logic              eretTake_i,
    input  logic              badFromPc_i,
    input  logic              badFromVaddr_i,

    // from the pipeline
    input  cp0Pkg::word_t     excPc_i,
    input  logic              inDelaySlot_i,
    input  cp0Pkg::word_t     vAddr_i,
    input  excPkg::hwInt_t    hwInt_i,

    // from the timer
    input  logic              timerInt_i,
    input  logic              timerMatch_i,
    input  cp0Pkg::word_t     count_i,
    input  cp0Pkg::word_t     compare_i,

    output cp0Pkg::word_t     status_o,
    output cp0Pkg::word_t     cause_o,
    output cp0Pkg::word_t     epc_o,
    output cp0Pkg::word_t     badVAddr_o,
    output cp0Pkg::word_t     rdData_o
);

    excPkg::hwInt_t hwIp;
    cp0Pkg::word_t  epcNext;

    // timer shares the IP7 line
    assign hwIp = {hwInt_i[excPkg::HwIntWidth-1] | timerInt_i,
                   hwInt_i[excPkg::HwIntWidth-2:0]};

    // delay slot faults restart at the branch
    assign epcNext = inDelaySlot_i ? (excPc_i - 32'd4) : excPc_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            status_o   <= cp0Pkg::StatusReset;
            cause_o    <= '0;
            epc_o      <= '0;
            badVAddr_o <= '0;
        end else begin
            cause_o[cp0Pkg::CauseHwIpHi:cp0Pkg::CauseHwIpLo] <= hwIp;
            if (timerMatch_i) begin
                cause_o[cp0Pkg::CauseTi] <= 1'b1;  // sticky until reset
            end

            //**********************************************************
            // software writes
            //**********************************************************
            if (wrEn_i) begin
                case (wrAddr_i)
                    cp0Pkg::RegStatus: begin
                        status_o[cp0Pkg::StatusImHi:cp0Pkg::StatusImLo] <=
                            wrData_i[cp0Pkg::StatusImHi:cp0Pkg::StatusImLo];
                        status_o[cp0Pkg::StatusExl] <= wrData_i[cp0Pkg::StatusExl];
                        status_o[cp0Pkg::StatusIe]  <= wrData_i[cp0Pkg::StatusIe];
                    end
                    cp0Pkg::RegCause: begin
                        // only the two software interrupt bits
                        cause_o[cp0Pkg::CauseSwIpHi:cp0Pkg::CauseSwIpLo] <=
                            wrData_i[cp0Pkg::CauseSwIpHi:cp0Pkg::CauseSwIpLo];
                    end
                    cp0Pkg::RegEpc: epc_o <= wrData_i;
                    default: ;  // BadVAddr, Count, Compare not written here
                endcase
            end

            //**********************************************************
            // exception capture, placed last so it wins
            //**********************************************************
            if (excTake_i) begin
                status_o[cp0Pkg::StatusExl] <= 1'b1;
                cause_o[cp0Pkg::CauseExcHi:cp0Pkg::CauseExcLo] <= excCode_i;

                // nested exceptions keep the first return address
                if (!status_o[cp0Pkg::StatusExl]) begin
                    epc_o                    <= epcNext;
                    cause_o[cp0Pkg::CauseBd] <= inDelaySlot_i;
                end

                if (badFromPc_i) begin
                    badVAddr_o <= excPc_i;
                end else if (badFromVaddr_i) begin
                    badVAddr_o <= vAddr_i;
                end
            end else if (eretTake_i) begin
                status_o[cp0Pkg::StatusExl] <= 1'b0;
            end
        end
    end

    //**********************************************************
    // read mux
    //**********************************************************
    always_comb begin
        case (rdAddr_i)
            cp0Pkg::RegBadVAddr: rdData_o = badVAddr_o;
            cp0Pkg::RegCount:    rdData_o = count_i;
            cp0Pkg::RegCompare:  rdData_o = compare_i;
            cp0Pkg::RegStatus:   rdData_o = status_o;
            cp0Pkg::RegCause:    rdData_o = cause_o;
            cp0Pkg::RegEpc:      rdData_o = epc_o;
            default:             rdData_o = '0;  // unmapped
        endcase
    end

endmodule

// ==== logic/cp0Top.sv ====
//**********************************************************
// CP0 top level
// ties the exception prioritizer, the timer and the
// register block together, CountDiv sets the timer rate
//**********************************************************

`timescale 1ns/1ps

module cp0Top #(
    parameter int CountDiv = 2
) (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              wrEn_i,
    input  cp0Pkg::regAddr_t  wrAddr_i,
    input  cp0Pkg::word_t     wrData_i,
    input  cp0Pkg::regAddr_t  rdAddr_i,
    input  excPkg::excFlags_t excFlags_i,
    input  cp0Pkg::word_t     excPc_i,
    input  logic              inDelaySlot_i,
    input  cp0Pkg::word_t     vAddr_i,
    input  excPkg::hwInt_t    hwInt_i,
    output cp0Pkg::word_t     rdData_o,
    output cp0Pkg::word_t     status_o,
    output cp0Pkg::word_t     cause_o,
    output cp0Pkg::word_t     epc_o,
    output cp0Pkg::word_t     badVAddr_o,
    output cp0Pkg::word_t     count_o,
    output cp0Pkg::word_t     compare_o,
    output logic              timerInt_o
);

    logic             excTake;
    excPkg::excCode_t excCode;
    logic             eretTake;
    logic             badFromPc;
    logic             badFromVaddr;
    logic             timerMatch;  // qualified Count == Compare

    excPrioritizer prio0 (
        .flags_i        (excFlags_i),
        .excTake_o      (excTake),
        .excCode_o      (excCode),
        .eretTake_o     (eretTake),
        .badFromPc_o    (badFromPc),
        .badFromVaddr_o (badFromVaddr)
    );

    cp0Timer #(.CountDiv(CountDiv)) timer0 (
        .clk          (clk),
        .reset_i      (reset_i),
        .wrEn_i       (wrEn_i),
        .wrAddr_i     (wrAddr_i),
        .wrData_i     (wrData_i),
        .count_o      (count_o),
        .compare_o    (compare_o),
        .timerInt_o   (timerInt_o),
        .timerMatch_o (timerMatch)
    );

    cp0Regs regs0 (
        .clk            (clk),
        .reset_i        (reset_i),
        .wrEn_i         (wrEn_i),
        .wrAddr_i       (wrAddr_i),
        .wrData_i       (wrData_i),
        .rdAddr_i       (rdAddr_i),
        .excTake_i      (excTake),
        .excCode_i      (excCode),
        .eretTake_i     (eretTake),
        .badFromPc_i    (badFromPc),
        .badFromVaddr_i (badFromVaddr),
        .excPc_i        (excPc_i),
        .inDelaySlot_i  (inDelaySlot_i),
        .vAddr_i        (vAddr_i),
        .hwInt_i        (hwInt_i),
        .timerInt_i     (timerInt_o),
        .timerMatch_i   (timerMatch),
        .count_i        (count_o),
        .compare_i      (compare_o),
        .status_o       (status_o),
        .cause_o        (cause_o),
        .epc_o          (epc_o),
        .badVAddr_o     (badVAddr_o),
        .rdData_o       (rdData_o)
    );

endmodule

// ==== dv/cp0Regs_chk.sv ====
//**********************************************************
// concurrent checks on the CP0 timer interrupt, nested
// exception capture and the read mux, bound into cp0Top
//**********************************************************

`timescale 1ns/1ps

module cp0Regs_chk (
    input logic             clk,
    input logic             reset_i,
    input logic             wrEn_i,
    input cp0Pkg::regAddr_t wrAddr_i,
    input cp0Pkg::regAddr_t rdAddr_i,
    input cp0Pkg::word_t    rdData_i,
    input logic             timerInt_i,
    input logic             timerMatch_i,
    input logic             excTake_i,
    input logic             exl_i,
    input cp0Pkg::word_t    epc_i
);

    int   failCount = 0;  // failed properties so far
    logic compareWr;
    logic epcWr;
    logic mapped;

    assign compareWr = wrEn_i && (wrAddr_i == cp0Pkg::RegCompare);
    assign epcWr     = wrEn_i && (wrAddr_i == cp0Pkg::RegEpc);
    assign mapped    = rdAddr_i inside {cp0Pkg::RegBadVAddr, cp0Pkg::RegCount,
                                        cp0Pkg::RegCompare, cp0Pkg::RegStatus,
                                        cp0Pkg::RegCause, cp0Pkg::RegEpc};

    //**********************************************************
    // timer interrupt
    //**********************************************************
    timerRise: assert property (@(posedge clk) disable iff (reset_i)
        $rose(timerInt_i) |-> $past(timerMatch_i))
    else begin
        failCount++;
        $error("timer interrupt rose without a qualified count match");
    end

    timerFall: assert property (@(posedge clk) disable iff (reset_i)
        $fell(timerInt_i) |-> $past(compareWr || reset_i))
    else begin
        failCount++;
        $error("timer interrupt fell without a Compare write");
    end

    // second exception at EXL keeps the first return address
    epcHold: assert property (@(posedge clk) disable iff (reset_i)
        (excTake_i && exl_i && !epcWr) |=> $stable(epc_i))
    else begin
        failCount++;
        $error("EPC changed on an exception taken with EXL set");
    end

    unmappedZero: assert property (@(posedge clk) disable iff (reset_i)
        !mapped |-> (rdData_i == '0))
    else begin
        failCount++;
        $error("read of an unmapped register returned nonzero data");
    end

endmodule

bind cp0Top cp0Regs_chk chk0 (
    .clk          (clk),
    .reset_i      (reset_i),
    .wrEn_i       (wrEn_i),
    .wrAddr_i     (wrAddr_i),
    .rdAddr_i     (rdAddr_i),
    .rdData_i     (rdData_o),
    .timerInt_i   (timerInt_o),
    .timerMatch_i (timerMatch),
    .excTake_i    (excTake),
    .exl_i        (status_o[cp0Pkg::StatusExl]),
    .epc_i        (epc_o)
);

// ==== dv/cp0Tb.sv ====
//**********************************************************
// testbench for the CP0 block
// drives cp0Top on the falling clock edge and checks reads,
// write masks, the timer and exception capture against a
// local model of the registers
//**********************************************************

`timescale 1ns/1ps

module cp0Tb;

    localparam int ClkPeriod  = 100;
    localparam int CountDiv   = 2;
    localparam int TestCycles = 20 + 60 + 25 + 80 + 10 + 20;  // per-test budgets
    localparam cp0Pkg::word_t StatusMask = 32'h0000_ff03;     // IM, EXL, IE
    localparam cp0Pkg::word_t SwIpMask   = 32'h0000_0300;

    logic              clk = 1'b0;
    logic              reset_i;
    logic              wrEn_i;
    cp0Pkg::regAddr_t  wrAddr_i;
    cp0Pkg::word_t     wrData_i;
    cp0Pkg::regAddr_t  rdAddr_i;
    excPkg::excFlags_t excFlags_i;
    cp0Pkg::word_t     excPc_i;
    logic              inDelaySlot_i;
    cp0Pkg::word_t     vAddr_i;
    excPkg::hwInt_t    hwInt_i;
    cp0Pkg::word_t     rdData_o;
    cp0Pkg::word_t     status_o;
    cp0Pkg::word_t     cause_o;
    cp0Pkg::word_t     epc_o;
    cp0Pkg::word_t     badVAddr_o;
    cp0Pkg::word_t     count_o;
    cp0Pkg::word_t     compare_o;
    logic              timerInt_o;

    // model of the registers
    cp0Pkg::word_t stat;
    cp0Pkg::word_t cause;
    cp0Pkg::word_t epc;
    cp0Pkg::word_t badV;

    cp0Pkg::word_t     lfsr;
    cp0Pkg::word_t     d;
    cp0Pkg::word_t     v;
    cp0Pkg::word_t     c;
    cp0Pkg::regAddr_t  a;
    excPkg::excFlags_t f;
    excPkg::hwInt_t    h;
    logic              intExp;
    int                lead;
    int                errsBefore;
    int                checks = 0;
    int                errors = 0;
    int unsigned       sinceReset;  // rising edges since reset went low

    cp0Top #(.CountDiv(CountDiv)) dut0 (
        .clk           (clk),
        .reset_i       (reset_i),
        .wrEn_i        (wrEn_i),
        .wrAddr_i      (wrAddr_i),
        .wrData_i      (wrData_i),
        .rdAddr_i      (rdAddr_i),
        .excFlags_i    (excFlags_i),
        .excPc_i       (excPc_i),
        .inDelaySlot_i (inDelaySlot_i),
        .vAddr_i       (vAddr_i),
        .hwInt_i       (hwInt_i),
        .rdData_o      (rdData_o),
        .status_o      (status_o),
        .cause_o       (cause_o),
        .epc_o         (epc_o),
        .badVAddr_o    (badVAddr_o),
        .count_o       (count_o),
        .compare_o     (compare_o),
        .timerInt_o    (timerInt_o)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        sinceReset <= reset_i ? 0 : sinceReset + 1;
    end

    // galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic cp0Pkg::word_t lfsrNext(input cp0Pkg::word_t s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic cp0Pkg::word_t randBits(input int n);
        cp0Pkg::word_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrNext(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic checkEq(input string name, input cp0Pkg::word_t got,
                           input cp0Pkg::word_t exp);
        checks++;
        assert (got === exp) else begin
            $display("FAIL %0t ns %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic writeReg(input cp0Pkg::regAddr_t addr, input cp0Pkg::word_t data);
        @(negedge clk);
        wrEn_i   = 1'b1;
        wrAddr_i = addr;
        wrData_i = data;
        @(negedge clk);
        wrEn_i = 1'b0;
    endtask

    task automatic readReg(input cp0Pkg::regAddr_t addr, input string name,
                           input cp0Pkg::word_t exp);
        @(negedge clk);
        rdAddr_i = addr;
        #1;  // read path is combinational
        checkEq(name, rdData_o, exp);
    endtask

    task automatic raiseException(input excPkg::excFlags_t flags);
        cp0Pkg::word_t    pc;
        cp0Pkg::word_t    va;
        logic             ds;
        int               top;
        excPkg::excCode_t code;
        pc = randBits(32);
        va = randBits(32);
        ds = 1'(randBits(1));
        @(negedge clk);
        excFlags_i    = flags;
        excPc_i       = pc;
        vAddr_i       = va;
        inDelaySlot_i = ds;
        @(negedge clk);
        excFlags_i = '0;

        // highest set flag decides
        top = -1;
        for (int i = 0; i < 9; i++) begin
            if (flags[i]) top = i;
        end
        case (top)
            excPkg::FlagAdIf:    code = excPkg::ExcAdEL;
            excPkg::FlagRi:      code = excPkg::ExcRi;
            excPkg::FlagSys:     code = excPkg::ExcSys;
            excPkg::FlagBp:      code = excPkg::ExcBp;
            excPkg::FlagOv:      code = excPkg::ExcOv;
            excPkg::FlagAdStore: code = excPkg::ExcAdES;
            excPkg::FlagAdLoad:  code = excPkg::ExcAdEL;
            default:             code = excPkg::ExcInt;
        endcase
        if (top == excPkg::FlagEret) begin
            stat[cp0Pkg::StatusExl] = 1'b0;
        end else if (top >= 0) begin
            if (!stat[cp0Pkg::StatusExl]) begin
                epc                    = ds ? pc - 32'd4 : pc;  // delay slot restarts at branch
                cause[cp0Pkg::CauseBd] = ds;
            end
            stat[cp0Pkg::StatusExl] = 1'b1;
            cause[cp0Pkg::CauseExcHi:cp0Pkg::CauseExcLo] = code;
            if (top == excPkg::FlagAdIf) badV = pc;
            else if (top <= excPkg::FlagAdStore) badV = va;
        end
        checkEq("status_o", status_o, stat);
        checkEq("cause_o", cause_o, cause);
        checkEq("epc_o", epc_o, epc);
        checkEq("badVAddr_o", badVAddr_o, badV);
    endtask

    task automatic reportTest(input string name, input int errsAtStart);
        $display("test %-10s done, %0d errors", name, errors - errsAtStart);
    endtask

    initial begin
        reset_i       = 1'b1;
        wrEn_i        = 1'b0;
        wrAddr_i      = '0;
        wrData_i      = '0;
        rdAddr_i      = '0;
        excFlags_i    = '0;
        excPc_i       = '0;
        inDelaySlot_i = 1'b0;
        vAddr_i       = '0;
        hwInt_i       = '0;
        lfsr          = 32'hdcac_7e0f;
        stat          = cp0Pkg::StatusReset;
        cause         = '0;
        epc           = '0;
        badV          = '0;
        repeat (2) @(negedge clk);
        reset_i = 1'b0;

        //**********************************************************
        // reset values and unmapped reads
        //**********************************************************
        errsBefore = errors;
        // one more edge passes inside readReg
        readReg(cp0Pkg::RegCount, "Count", cp0Pkg::word_t'((sinceReset + 1) / CountDiv));
        readReg(cp0Pkg::RegStatus, "Status", stat);
        readReg(cp0Pkg::RegCause, "Cause", cause);
        readReg(cp0Pkg::RegEpc, "EPC", epc);
        readReg(cp0Pkg::RegBadVAddr, "BadVAddr", badV);
        readReg(cp0Pkg::RegCompare, "Compare", '0);
        repeat (6) begin
            a = cp0Pkg::regAddr_t'(randBits(5));
            if (!(a inside {cp0Pkg::RegBadVAddr, cp0Pkg::RegCount, cp0Pkg::RegCompare,
                            cp0Pkg::RegStatus, cp0Pkg::RegCause, cp0Pkg::RegEpc})) begin
                readReg(a, "rdData_o unmapped", '0);
            end
        end
        reportTest("reset", errsBefore);

        //**********************************************************
        // software write masks
        //**********************************************************
        errsBefore = errors;
        repeat (4) begin
            d = randBits(32);
            writeReg(cp0Pkg::RegStatus, d);
            stat = (stat & ~StatusMask) | (d & StatusMask);
            readReg(cp0Pkg::RegStatus, "Status", stat);
            d = randBits(32);
            writeReg(cp0Pkg::RegCause, d);
            cause = (cause & ~SwIpMask) | (d & SwIpMask);
            readReg(cp0Pkg::RegCause, "Cause", cause);
            d = randBits(32);
            writeReg(cp0Pkg::RegEpc, d);
            epc = d;
            readReg(cp0Pkg::RegEpc, "EPC", epc);
            writeReg(cp0Pkg::RegBadVAddr, randBits(32));  // read only
            readReg(cp0Pkg::RegBadVAddr, "BadVAddr", badV);
        end
        writeReg(cp0Pkg::RegStatus, '0);
        stat = stat & ~StatusMask;
        writeReg(cp0Pkg::RegCause, '0);
        cause = cause & ~SwIpMask;
        reportTest("masks", errsBefore);

        //**********************************************************
        // timer
        //**********************************************************
        errsBefore = errors;
        v = randBits(31);
        c = v + 32'd3;  // nonzero, reached after six edges
        intExp = 1'b0;
        writeReg(cp0Pkg::RegCount, v);
        for (int k = 0; k < 12; k++) begin
            checkEq("count_o", count_o, v + cp0Pkg::word_t'(k / CountDiv));
            checkEq("timerInt_o", {31'd0, timerInt_o}, {31'd0, intExp});
            if (k > 0 && v + cp0Pkg::word_t'(k / CountDiv) == c) intExp = 1'b1;
            wrEn_i   = (k == 0);  // Compare goes in on the first edge
            wrAddr_i = cp0Pkg::RegCompare;
            wrData_i = c;
            @(negedge clk);
        end
        cause[cp0Pkg::CauseTi]     = 1'b1;
        cause[cp0Pkg::CauseHwIpHi] = 1'b1;  // IP7 follows the timer
        readReg(cp0Pkg::RegCause, "Cause", cause);
        writeReg(cp0Pkg::RegCompare, v + 32'h0010_0000);
        checkEq("timerInt_o", {31'd0, timerInt_o}, '0);
        checkEq("compare_o", compare_o, v + 32'h0010_0000);
        cause[cp0Pkg::CauseHwIpHi] = 1'b0;
        readReg(cp0Pkg::RegCause, "Cause", cause);
        readReg(cp0Pkg::RegCompare, "Compare", v + 32'h0010_0000);
        reportTest("timer", errsBefore);

        //**********************************************************
        // exception priority and capture, EXL clear
        //**********************************************************
        errsBefore = errors;
        for (int t = 0; t < 18; t++) begin
            lead = t % 9;
            f = excPkg::excFlags_t'(1 << lead) |
                (excPkg::excFlags_t'(randBits(9)) & excPkg::excFlags_t'((1 << lead) - 1));
            raiseException(f);
            if (stat[cp0Pkg::StatusExl]) begin
                writeReg(cp0Pkg::RegStatus, '0);
                stat[cp0Pkg::StatusExl] = 1'b0;
            end
        end
        reportTest("priority", errsBefore);

        // nested exception keeps EPC, then eret
        errsBefore = errors;
        raiseException(excPkg::excFlags_t'(1 << excPkg::FlagSys));
        raiseException(excPkg::excFlags_t'(1 << excPkg::FlagOv));
        raiseException(excPkg::excFlags_t'(1 << excPkg::FlagEret));
        reportTest("nested", errsBefore);

        //**********************************************************
        // hardware interrupt lines
        //**********************************************************
        errsBefore = errors;
        repeat (6) begin
            h = excPkg::hwInt_t'(randBits(6));
            if (h == '0) h = 6'h01;
            @(negedge clk);
            hwInt_i = h;
            @(negedge clk);
            cause[cp0Pkg::CauseHwIpHi:cp0Pkg::CauseHwIpLo] = h;
            checkEq("cause_o", cause_o, cause);
        end
        raiseException(excPkg::excFlags_t'(1 << excPkg::FlagInt));
        raiseException(excPkg::excFlags_t'(1 << excPkg::FlagEret));
        reportTest("hwint", errsBefore);

        $display("%0d checks, %0d errors, %0d assertion errors",
                 checks, errors, dut0.chk0.failCount);
        if (errors == 0 && dut0.chk0.failCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(ClkPeriod * (TestCycles + 50));
        $display("watchdog expired before the tests finished");
        $display("Regression failed");
        $finish;
    end

endmodule

// ==== tb.f ====
logic/cp0Pkg.sv
logic/excPkg.sv
logic/excPrioritizer.sv
logic/cp0Timer.sv
logic/cp0Regs.sv
logic/cp0Top.sv
dv/cp0Regs_chk.sv
dv/cp0Tb.sv

// ==== Makefile ====
TOP = cp0Tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run the regression"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f tb.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Regression passed$$"

clean:
	rm -rf obj_dir
